// ==== spi_rx_top.f ====
+incdir+.
spi_rx_bus_pkg.sv
spi_rx_data_pkg.sv
spi_rx_lane.sv
spi_rx_merge.sv
spi_rx_regs.sv
spi_rx_top.sv
tb_clock_gen.sv
tb_spi_rx_top.sv

// ==== tb_spi_rx_top.sv ====
// testbench with random serial frames, lane models, credit consumer, register and word checks.
`timescale 1ns/1ps
`default_nettype none
`include "spi_rx_config.svh"

module tb_spi_rx_top;
    import spi_rx_data_pkg::*;
    import spi_rx_bus_pkg::*;

    localparam int MAX_CYCLES = 20000;  // all phases with wide margin.

    logic                       SCLK;
    logic                       RST;
    logic                       sdi_a;
    logic                       sen_a;
    logic                       sdi_b;
    logic                       sen_b;
    logic                       credit_return;
    logic                       out_valid;
    logic [7:0]                 bus_rdata;
    logic [7:0]                 rd_val;
    bus_req_t                   bus_req;
    spi_word_t                  out_word;
    spi_word_t                  exp_a [$];
    spi_word_t                  exp_b [$];
    logic [`SPI_RX_FRAME_W-1:0] frame_model [2];
    logic [1:0]                 en_model = 2'b00;
    int                         seed     = 10;
    int                         cycles   = 0;
    int                         sent     = 0;
    int                         returned = 0;
    int                         ret_wait = 0;
    int                         idle_cnt = 0;
    int                         got [2]    = '{0, 0};
    int                         pushed [2] = '{0, 0};
    logic                       hold  = 1'b0;   // consumer keeps its credits.
    logic                       lossy = 1'b0;   // lane buffers may drop words.

    tb_clock_gen #(.PERIOD_NS(4)) clock_gen_i (.SCLK(SCLK));

    spi_rx_top spi_rx_top_i (
        .SCLK(SCLK), .RST(RST), .sdi_a(sdi_a), .sen_a(sen_a), .sdi_b(sdi_b),
        .sen_b(sen_b), .bus_req(bus_req), .bus_rdata(bus_rdata),
        .credit_return(credit_return), .out_valid(out_valid), .out_word(out_word)
    );

    // ****************************************
    // checking and reporting.
    // ****************************************
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED at %0t ns: %s expected 0x%0h actual 0x%0h",
                     $time, name, expected, actual);
            $display("Regression failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        $display("Regression failed");
        $fatal(1, "run stopped");
    endtask

    always @(posedge SCLK) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Regression failed");
            $fatal(1, "timeout");
        end
    end

    // ****************************************
    // lane models.
    // ****************************************
    function automatic int queue_size(input int lane);
        return (lane == 0) ? exp_a.size() : exp_b.size();
    endfunction

    function automatic spi_word_t pop_expected(input int lane);
        if (lane == 0) begin
            return exp_a.pop_front();
        end
        return exp_b.pop_front();
    endfunction

    // a disabled lane stores nothing.
    task automatic expect_word(input int lane, input logic [`SPI_RX_DATA_W-1:0] data);
        spi_word_t w;
        if (en_model[lane]) begin
            w.id    = `SPI_RX_ID_W'(lane + 1);
            w.frame = frame_model[lane];
            w.data  = data;
            if (lane == 0) begin
                exp_a.push_back(w);
            end else begin
                exp_b.push_back(w);
            end
            pushed[lane]++;
        end
    endtask

    task automatic set_lane(input int lane, input logic sen, input logic sdi);
        if (lane == 0) begin
            sen_a = sen;
            sdi_a = sdi;
        end else begin
            sen_b = sen;
            sdi_b = sdi;
        end
    endtask

    // frames of min_len + k * step bits, msb first, gaps of 1 to 5 cycles.
    task automatic drive_lane(input int lane, input int frames, input int min_len,
                              input int max_len, input int step);
        int                        len;
        int                        nbits;
        logic                      bit_v;
        logic [`SPI_RX_DATA_W-1:0] acc;
        for (int f = 0; f < frames; f++) begin
            len   = min_len + step * ($unsigned($random(seed)) % ((max_len - min_len) / step + 1));
            acc   = '0;
            nbits = 0;
            for (int i = 0; i < len; i++) begin
                @(negedge SCLK);
                bit_v = $random(seed);
                set_lane(lane, 1'b1, bit_v);
                acc = {acc[`SPI_RX_DATA_W-2:0], bit_v};
                nbits++;
                if (nbits == `SPI_RX_DATA_W) begin
                    expect_word(lane, acc);
                    acc   = '0;
                    nbits = 0;
                end
            end
            if (nbits != 0) begin
                expect_word(lane, acc);     // right aligned, zero filled.
            end
            if (en_model[lane]) begin
                frame_model[lane]++;
            end
            repeat (1 + ($unsigned($random(seed)) % 5)) begin
                @(negedge SCLK);
                set_lane(lane, 1'b0, 1'b0);
            end
        end
    endtask

    task automatic run_frames(input int frames, input int min_len, input int max_len,
                              input int step);
        fork
            drive_lane(0, frames, min_len, max_len, step);
            drive_lane(1, frames, min_len, max_len, step);
        join
    endtask

    // ****************************************
    // output consumer.
    // ****************************************
    task automatic take_word(input spi_word_t w);
        spi_word_t e;
        int        lane;
        logic      found;
        if (w.id != 4'd1 && w.id != 4'd2) begin
            report_error("output word carries an unknown lane id");
        end else begin
            lane  = w.id - 1;
            found = 1'b0;
            got[lane]++;
            while (!found) begin
                if (queue_size(lane) == 0) begin
                    report_error("output word arrived while no word was expected");
                end else begin
                    e = pop_expected(lane);
                    if (!lossy || e == w) begin   // dropped words are skipped.
                        check_value("out_word", e, w);
                        found = 1'b1;
                    end
                end
            end
        end
    endtask

    always @(negedge SCLK) begin
        if (!RST) begin
            if (out_valid) begin
                sent++;
                idle_cnt = 0;
                if (sent - returned > `SPI_RX_CREDITS) begin
                    report_error("out_valid pulse without an available credit");
                end else begin
                    take_word(out_word);
                end
            end else begin
                idle_cnt++;
            end
            if (!hold && sent > returned && ret_wait == 0) begin
                credit_return = 1'b1;
                returned++;
                ret_wait = $unsigned($random(seed)) % 4;   // random return delay.
            end else begin
                credit_return = 1'b0;
                if (ret_wait > 0) begin
                    ret_wait--;
                end
            end
        end
    end

    // ****************************************
    // bus access and waits.
    // ****************************************
    task automatic bus_write(input logic [3:0] addr, input logic [7:0] data);
        @(negedge SCLK);
        bus_req.op    = BUS_WRITE;
        bus_req.addr  = addr;
        bus_req.wdata = data;
        @(negedge SCLK);
        bus_req.op = BUS_NOP;
    endtask

    task automatic bus_read(input logic [3:0] addr, output logic [7:0] data);
        @(negedge SCLK);
        bus_req.op    = BUS_READ;
        bus_req.addr  = addr;
        bus_req.wdata = 8'h00;
        @(negedge SCLK);
        data       = bus_rdata;     // registered one cycle after the request.
        bus_req.op = BUS_NOP;
    endtask

    task automatic check_reg(input logic [3:0] addr, input logic [7:0] expected,
                             input string name);
        logic [7:0] data;
        bus_read(addr, data);
        check_value(name, expected, data);
    endtask

    task automatic set_enables(input logic [1:0] en);
        bus_write(REG_ENABLE, {6'b0, en});
        en_model = en;
    endtask

    task automatic wait_drained();
        while (exp_a.size() != 0 || exp_b.size() != 0 || sent != returned) begin
            @(posedge SCLK);
        end
    endtask

    task automatic wait_quiet();
        while (sent != returned || idle_cnt < 40) begin
            @(posedge SCLK);
        end
    endtask

    // ****************************************
    // test sequence.
    // ****************************************
    initial begin
        RST           = 1'b1;
        sdi_a         = 1'b0;
        sen_a         = 1'b0;
        sdi_b         = 1'b0;
        sen_b         = 1'b0;
        credit_return = 1'b0;
        bus_req.op    = BUS_NOP;
        bus_req.addr  = '0;
        bus_req.wdata = '0;
        frame_model[0] = '0;
        frame_model[1] = '0;
        repeat (2) @(posedge SCLK);
        @(negedge SCLK);
        RST = 1'b0;

        // full 16 and 32 bit frames on both lanes.
        set_enables(2'b11);
        check_reg(REG_ENABLE, 8'h03, "reg_enable");
        run_frames(6, 16, 32, 16);
        wait_drained();

        // random lengths with partial words.
        run_frames(12, 1, 40, 1);
        wait_drained();

        // lane b off, its frames must leave no trace.
        set_enables(2'b01);
        check_reg(REG_ENABLE, 8'h01, "reg_enable");
        run_frames(8, 1, 40, 1);
        wait_drained();
        set_enables(2'b11);

        // credits withheld, then released.
        hold = 1'b1;
        run_frames(4, 32, 32, 1);
        while (sent - returned != `SPI_RX_CREDITS) begin
            @(posedge SCLK);
        end
        bus_read(REG_FILL, rd_val);
        check_value("reg_fill while credits held", 1, rd_val != 0);
        hold = 1'b0;
        wait_drained();

        // overflow of the lane buffers.
        hold  = 1'b1;
        lossy = 1'b1;
        run_frames(8, 40, 40, 1);
        check_reg(REG_FILL, 8'd16, "reg_fill");
        hold = 1'b0;
        wait_quiet();
        bus_read(REG_LOST_A, rd_val);
        check_value("lane a words lost", 1, rd_val != 0);
        check_value("lane a received plus lost", pushed[0], got[0] + rd_val);
        bus_read(REG_LOST_B, rd_val);
        check_value("lane b words lost", 1, rd_val != 0);
        check_value("lane b received plus lost", pushed[1], got[1] + rd_val);
        exp_a.delete();
        exp_b.delete();
        lossy = 1'b0;

        // soft clear resets counters, enables and frame numbers.
        bus_write(REG_SOFT_RST, 8'h5a);
        en_model       = 2'b00;
        frame_model[0] = '0;
        frame_model[1] = '0;
        check_reg(REG_LOST_A, 8'h00, "reg_lost_a");
        check_reg(REG_LOST_B, 8'h00, "reg_lost_b");
        check_reg(REG_ENABLE, 8'h00, "reg_enable");
        check_reg(4'hf, 8'h00, "unmapped register");
        set_enables(2'b11);
        run_frames(4, 1, 40, 1);
        wait_drained();

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
// free-running testbench clock.
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic SCLK
);

    initial begin
        SCLK = 1'b0;
    end

    always #(PERIOD_NS / 2.0) SCLK = ~SCLK;   // 50 percent duty.

endmodule

`default_nettype wire

// ==== spi_rx_top.sv ====
// top level with two serial lanes, the merge stage and the register block.
`timescale 1ns/1ps
`default_nettype none

module spi_rx_top (
    input  wire logic                     SCLK,
    input  wire logic                     RST,
    input  wire logic                     sdi_a,
    input  wire logic                     sen_a,
    input  wire logic                     sdi_b,
    input  wire logic                     sen_b,
    input  wire spi_rx_bus_pkg::bus_req_t bus_req,
    output logic [7:0]                    bus_rdata,
    input  wire logic                     credit_return,
    output logic                          out_valid,
    output spi_rx_data_pkg::spi_word_t    out_word
);
    import spi_rx_data_pkg::*;

    spi_word_t  word_a;
    spi_word_t  word_b;
    logic       valid_a;
    logic       valid_b;
    logic       pop_a;
    logic       pop_b;
    logic       enable_a;
    logic       enable_b;
    logic       soft_clr;
    logic [7:0] lost_a;
    logic [7:0] lost_b;
    logic [4:0] fill_level;

    // ****************************************
    // serial lanes.
    // ****************************************
    spi_rx_lane #(.LANE_ID(4'd1)) lane_a (
        .SCLK(SCLK), .RST(RST), .soft_clr(soft_clr), .enable(enable_a),
        .sdi(sdi_a), .sen(sen_a), .lane_pop(pop_a), .lane_valid(valid_a),
        .lane_word(word_a), .lost_count(lost_a)
    );

    spi_rx_lane #(.LANE_ID(4'd2)) lane_b (
        .SCLK(SCLK), .RST(RST), .soft_clr(soft_clr), .enable(enable_b),
        .sdi(sdi_b), .sen(sen_b), .lane_pop(pop_b), .lane_valid(valid_b),
        .lane_word(word_b), .lost_count(lost_b)
    );

    // merge and output credits.
    spi_rx_merge merge_i (
        .SCLK(SCLK), .RST(RST), .soft_clr(soft_clr),
        .word_a(word_a), .word_b(word_b), .valid_a(valid_a), .valid_b(valid_b),
        .pop_a(pop_a), .pop_b(pop_b), .credit_return(credit_return),
        .out_valid(out_valid), .out_word(out_word), .fill_level(fill_level)
    );

    spi_rx_regs regs_i (
        .SCLK(SCLK), .RST(RST), .bus_req(bus_req), .bus_rdata(bus_rdata),
        .enable_a(enable_a), .enable_b(enable_b), .soft_clr(soft_clr),
        .lost_a(lost_a), .lost_b(lost_b), .fill_level(fill_level)
    );

endmodule

`default_nettype wire

// ==== spi_rx_regs.sv ====
// register block with bus decode, lane enables, soft clear pulse and read-back mux.
`timescale 1ns/1ps
`default_nettype none

module spi_rx_regs (
    input  wire logic                     SCLK,
    input  wire logic                     RST,
    input  wire spi_rx_bus_pkg::bus_req_t bus_req,
    output logic [7:0]                    bus_rdata,
    output logic                          enable_a,
    output logic                          enable_b,
    output logic                          soft_clr,
    input  wire logic [7:0]               lost_a,
    input  wire logic [7:0]               lost_b,
    input  wire logic [4:0]               fill_level
);
    import spi_rx_bus_pkg::*;

    logic       wr_req;
    logic       rd_req;
    logic [1:0] enable_q;

    // ****************************************
    // request decode.
    // ****************************************
    assign wr_req = (bus_req.op == BUS_WRITE);
    assign rd_req = (bus_req.op == BUS_READ);

    assign enable_a = enable_q[0];
    assign enable_b = enable_q[1];

    // one cycle pulse after any write to the soft reset address.
    always_ff @(posedge SCLK) begin
        if (RST) begin
            soft_clr <= 1'b0;
        end else begin
            soft_clr <= wr_req && (bus_req.addr == REG_SOFT_RST);
        end
    end

    // soft clear drops both enables as well.
    always_ff @(posedge SCLK) begin
        if (RST || soft_clr) begin
            enable_q <= 2'b00;
        end else if (wr_req && (bus_req.addr == REG_ENABLE)) begin
            enable_q <= bus_req.wdata[1:0];
        end
    end

    // ****************************************
    // read back.
    // ****************************************
    always_ff @(posedge SCLK) begin
        if (rd_req) begin
            case (bus_req.addr)
                REG_ENABLE: begin
                    bus_rdata <= {6'b0, enable_q};
                end
                REG_LOST_A: begin
                    bus_rdata <= lost_a;
                end
                REG_LOST_B: begin
                    bus_rdata <= lost_b;
                end
                REG_FILL: begin
                    bus_rdata <= {3'b0, fill_level};    // 0 to 16.
                end
                default: begin
                    bus_rdata <= 8'h00;     // soft reset and unmapped.
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== spi_rx_merge.sv ====
// round-robin merge of two lanes into the output FIFO, with output credit counter.
`timescale 1ns/1ps
`default_nettype none
`include "spi_rx_config.svh"

module spi_rx_merge (
    input  wire logic                       SCLK,
    input  wire logic                       RST,
    input  wire logic                       soft_clr,
    input  wire spi_rx_data_pkg::spi_word_t word_a,
    input  wire spi_rx_data_pkg::spi_word_t word_b,
    input  wire logic                       valid_a,
    input  wire logic                       valid_b,
    output logic                            pop_a,
    output logic                            pop_b,
    input  wire logic                       credit_return,
    output logic                            out_valid,
    output spi_rx_data_pkg::spi_word_t      out_word,
    output logic [4:0]                      fill_level
);
    import spi_rx_data_pkg::*;

    localparam int FAW = $clog2(`SPI_RX_FIFO_DEPTH);
    localparam int CRW = $clog2(`SPI_RX_CREDITS + 1);
    localparam logic [FAW:0]   FIFO_DEPTH  = (FAW + 1)'(`SPI_RX_FIFO_DEPTH);
    localparam logic [CRW-1:0] CREDIT_INIT = CRW'(`SPI_RX_CREDITS);

    logic           rr_b;           // lane b wins the next tie.
    logic           room;
    logic           stage_valid;
    spi_word_t      stage_word;
    spi_word_t      fifo_mem [`SPI_RX_FIFO_DEPTH];
    logic [FAW:0]   wr_ptr;
    logic [FAW:0]   rd_ptr;
    logic [FAW:0]   fifo_count;
    logic           fifo_rd;
    logic [CRW-1:0] credit_cnt;

    // ****************************************
    // lane arbitration.
    // ****************************************
    assign fifo_count = wr_ptr - rd_ptr;

    // the staged word already owns a slot.
    assign room = (fifo_count + {{FAW{1'b0}}, stage_valid}) < FIFO_DEPTH;

    assign pop_a = room && valid_a && (!valid_b || !rr_b);
    assign pop_b = room && valid_b && (!valid_a || rr_b);

    // ****************************************
    // output fifo and credits.
    // ****************************************
    assign fifo_rd    = (fifo_count != '0) && (credit_cnt != '0);
    assign fill_level = fifo_count;

    always_ff @(posedge SCLK) begin
        if (RST || soft_clr) begin
            rr_b        <= 1'b0;
            stage_valid <= 1'b0;
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            out_valid   <= 1'b0;
            credit_cnt  <= CREDIT_INIT;
        end else begin
            stage_valid <= pop_a || pop_b;
            if (pop_a) begin
                rr_b <= 1'b1;
            end else if (pop_b) begin
                rr_b <= 1'b0;
            end
            if (stage_valid) begin
                wr_ptr <= wr_ptr + 1'b1;    // popped word lands one cycle later.
            end
            if (fifo_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            out_valid <= fifo_rd;
            // one credit spent per word, one back per return cycle.
            case ({fifo_rd, credit_return})
                2'b10: begin
                    credit_cnt <= credit_cnt - 1'b1;
                end
                2'b01: begin
                    credit_cnt <= credit_cnt + 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge SCLK) begin
        if (pop_a) begin
            stage_word <= word_a;
        end else if (pop_b) begin
            stage_word <= word_b;
        end
    end

    always_ff @(posedge SCLK) begin
        if (stage_valid) begin
            fifo_mem[wr_ptr[FAW-1:0]] <= stage_word;
        end
        if (fifo_rd) begin
            out_word <= fifo_mem[rd_ptr[FAW-1:0]]; // valid with out_valid.
        end
    end

endmodule

`default_nettype wire

// ==== spi_rx_lane.sv ====
// one serial lane with sen edge detection, word assembly, frame tag, word buffer, lost counter.
`timescale 1ns/1ps
`default_nettype none
`include "spi_rx_config.svh"

module spi_rx_lane #(
    parameter logic [`SPI_RX_ID_W-1:0] LANE_ID = `SPI_RX_ID_W'(1)
) (
    input  wire logic                  SCLK,
    input  wire logic                  RST,
    input  wire logic                  soft_clr,
    input  wire logic                  enable,
    input  wire logic                  sdi,
    input  wire logic                  sen,
    input  wire logic                  lane_pop,
    output logic                       lane_valid,
    output spi_rx_data_pkg::spi_word_t lane_word,
    output logic [7:0]                 lost_count
);
    import spi_rx_data_pkg::*;

    localparam int BIT_W = $clog2(`SPI_RX_DATA_W);
    localparam int LAW   = $clog2(`SPI_RX_LANE_DEPTH);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`SPI_RX_DATA_W - 1);

    lane_state_e                state;
    lane_state_e                state_nxt;
    logic                       sen_dly;
    logic                       start_det;
    logic                       end_det;
    logic                       shift_en;
    logic                       word_done;
    logic                       flush;
    logic                       wr_en;
    logic                       buf_full;
    logic [BIT_W-1:0]           bit_cnt;
    logic [`SPI_RX_DATA_W-1:0]  shift_q;
    logic [`SPI_RX_FRAME_W-1:0] frame_cnt;
    spi_word_t                  wr_word;
    spi_word_t                  buf_mem [`SPI_RX_LANE_DEPTH];
    logic [LAW:0]               wr_ptr;
    logic [LAW:0]               rd_ptr;

    // ****************************************
    // framing.
    // ****************************************
    always_ff @(posedge SCLK) begin
        if (RST) begin
            sen_dly <= 1'b0;
        end else begin
            sen_dly <= sen;
        end
    end

    assign start_det = sen && !sen_dly;
    assign end_det   = !sen && sen_dly;

    always_comb begin
        state_nxt = state;
        case (state)
            LANE_IDLE: begin
                if (enable && start_det) begin
                    state_nxt = LANE_SHIFT;
                end
            end
            LANE_SHIFT: begin
                if (!enable) begin
                    state_nxt = LANE_IDLE;
                end else if (end_det) begin
                    // only a frame with leftover bits needs a flush.
                    state_nxt = (bit_cnt != '0) ? LANE_FLUSH : LANE_IDLE;
                end
            end
            LANE_FLUSH: begin
                state_nxt = (enable && start_det) ? LANE_SHIFT : LANE_IDLE; // back to back frames.
            end
            default: begin
                state_nxt = LANE_IDLE;
            end
        endcase
    end

    assign shift_en  = (state_nxt == LANE_SHIFT);
    assign word_done = shift_en && (bit_cnt == LAST_BIT);   // 16th bit sampled now.
    assign flush     = (state_nxt == LANE_FLUSH);
    assign wr_en     = word_done || flush;

    always_ff @(posedge SCLK) begin
        if (RST || soft_clr) begin
            state     <= LANE_IDLE;
            bit_cnt   <= '0;
            frame_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (shift_en && !word_done) begin
                bit_cnt <= bit_cnt + 1'b1;
            end else begin
                bit_cnt <= '0;
            end
            if (end_det && enable) begin
                frame_cnt <= frame_cnt + 1'b1;  // after the word of this frame is tagged.
            end
        end
    end

    // cleared between words, so a short word comes out zero filled.
    always_ff @(posedge SCLK) begin
        if (shift_en && !word_done) begin
            shift_q <= {shift_q[`SPI_RX_DATA_W-2:0], sdi};
        end else begin
            shift_q <= '0;
        end
    end

    // ****************************************
    // word buffer and lost counter.
    // ****************************************
    assign wr_word.id    = LANE_ID;
    assign wr_word.frame = frame_cnt;
    assign wr_word.data  = word_done ? {shift_q[`SPI_RX_DATA_W-2:0], sdi} : shift_q;

    assign buf_full   = (wr_ptr[LAW] != rd_ptr[LAW]) && (wr_ptr[LAW-1:0] == rd_ptr[LAW-1:0]);
    assign lane_valid = (wr_ptr != rd_ptr);
    assign lane_word  = buf_mem[rd_ptr[LAW-1:0]];

    always_ff @(posedge SCLK) begin
        if (RST || soft_clr) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            lost_count <= '0;
        end else begin
            if (wr_en && !buf_full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (lane_pop && lane_valid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_en && buf_full && (lost_count != 8'hff)) begin
                lost_count <= lost_count + 8'd1; // saturates.
            end
        end
    end

    always_ff @(posedge SCLK) begin
        if (wr_en && !buf_full) begin
            buf_mem[wr_ptr[LAW-1:0]] <= wr_word;
        end
    end

endmodule

`default_nettype wire

// ==== spi_rx_data_pkg.sv ====
// tagged word struct and lane framing state for the serial data path.
`default_nettype none
`include "spi_rx_config.svh"

package spi_rx_data_pkg;

    // ****************************************
    // tagged output word.
    // ****************************************
    // id in the top bits, then frame number, then data.
    typedef struct packed {
        logic [`SPI_RX_ID_W-1:0]    id;
        logic [`SPI_RX_FRAME_W-1:0] frame;
        logic [`SPI_RX_DATA_W-1:0]  data;   // right aligned on a short word.
    } spi_word_t;

    // ****************************************
    // lane framing state.
    // ****************************************
    typedef enum logic [1:0] {
        LANE_IDLE  = 2'd0,  // outside a frame.
        LANE_SHIFT = 2'd1,  // collecting bits.
        LANE_FLUSH = 2'd2   // partial word just written on an early end.
    } lane_state_e;

endpackage

`default_nettype wire

// ==== spi_rx_bus_pkg.sv ====
// register bus opcodes, register map and bus request struct.
`default_nettype none
`include "spi_rx_config.svh"

package spi_rx_bus_pkg;

    // ****************************************
    // bus opcodes and register map.
    // ****************************************
    typedef enum logic [1:0] {
        BUS_NOP   = 2'd0,   // idle cycle.
        BUS_WRITE = 2'd1,
        BUS_READ  = 2'd2    // data returns next cycle.
    } bus_op_e;

    typedef enum logic [`SPI_RX_ADDR_W-1:0] {
        REG_SOFT_RST = 0,   // write only, any value.
        REG_ENABLE   = 1,   // bit 0 lane a, bit 1 lane b.
        REG_LOST_A   = 2,
        REG_LOST_B   = 3,
        REG_FILL     = 4    // output fifo fill level.
    } reg_addr_e;

    // one request per cycle.
    // addr is plain so that unmapped addresses can be issued.
    typedef struct packed {
        bus_op_e                   op;
        logic [`SPI_RX_ADDR_W-1:0] addr;
        logic [7:0]                wdata;
    } bus_req_t;

endpackage

`default_nettype wire

// ==== spi_rx_config.svh ====
// word widths, buffer depths, output credit count and register address width.
`ifndef SPI_RX_CONFIG_SVH
`define SPI_RX_CONFIG_SVH

// ****************************************
// tagged word layout.
// ****************************************
// data bits collected per word.
`define SPI_RX_DATA_W      16
// frame number carried by every word.
`define SPI_RX_FRAME_W     12
`define SPI_RX_ID_W        4

// ****************************************
// buffering and flow control.
// ****************************************
`define SPI_RX_LANE_DEPTH  4
`define SPI_RX_FIFO_DEPTH  16
// credits held by the consumer after reset.
`define SPI_RX_CREDITS     4

// register bus address width.
`define SPI_RX_ADDR_W      4

`endif
